// File: tc_pkg.sv
`default_nettype none

package tc_pkg;

    localparam int WORD_W = 32;

    typedef enum logic {
        INT8 = 1'b0,
        INT4 = 1'b1
    } elem_type_e;

    typedef enum logic [1:0] {
        MAT_C = 2'd0,
        MAT_A = 2'd1,
        MAT_B = 2'd2
    } mat_sel_e;

    typedef logic signed [7:0] lane8_t;
    typedef logic signed [3:0] lane4_t;

    // Lane 0 sits in the low bits in both views
    typedef union packed {
        lane8_t [3:0] i8;
        lane4_t [7:0] i4;
    } lane_word_u;

    localparam logic [WORD_W-1:0] C_BASE = 32'h0001_0000;
    localparam logic [WORD_W-1:0] A_BASE = 32'h0010_0000;
    localparam logic [WORD_W-1:0] B_BASE = 32'h0100_0000;

    typedef enum logic [2:0] {
        IDLE,
        READ_C,
        LOAD_A,
        LOAD_B,
        COMPUTE,
        DRAIN
    } phase_e;

    function automatic int lanes_per_word(elem_type_e t);
        return (t == INT4) ? 8 : 4;
    endfunction

    function automatic int operand_beats(int dim, int k, elem_type_e t);
        return dim * k / lanes_per_word(t);
    endfunction

    // Width of the k offset, which also carries the C column
    function automatic int pos_w(int dim, int k);
        return $clog2((k > dim) ? k : dim);
    endfunction

endpackage

`default_nettype wire

// File: tc_if.sv
`timescale 1ns/1ps
`default_nettype none

interface operand_write_if #(
    parameter int DIM = 4,
    parameter int K   = 8
);
    logic                                  we;
    tc_pkg::mat_sel_e                      mat;
    logic [$clog2(DIM)-1:0]                row;       // Row of A, column of B, row of C
    logic [tc_pkg::pos_w(DIM, K)-1:0]      k_base;    // Column index for C writes
    tc_pkg::lane_word_u                    lanes;
    tc_pkg::elem_type_e                    elem_type;
    logic [tc_pkg::WORD_W-1:0]             word;

    modport loader (output we, mat, row, k_base, lanes, elem_type, word);
    modport sink   (input  we, mat, row, k_base, lanes, elem_type, word);
endinterface

interface result_if #(
    parameter int DIM = 4
);
    logic                              valid;
    logic                              ready;
    logic [tc_pkg::WORD_W-1:0]         data;
    logic                              last;
    logic [$clog2(DIM*DIM+1)-1:0]      index;    // Word the drain wants next

    modport source (output valid, data, last, input index);
    modport drain  (input valid, data, last, output ready, index);
endinterface

`default_nettype wire

// File: tc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tc_sequencer #(
    parameter int DIM = 4,
    parameter int K   = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  tc_pkg::elem_type_e        elem_type,
    input  logic                      req_ready,
    input  logic                      in_valid,
    input  logic                      in_last,
    input  logic                      drain_done,
    output tc_pkg::phase_e            phase,
    output logic                      req_valid,
    output tc_pkg::mat_sel_e          req_sel,
    output logic [tc_pkg::WORD_W-1:0] req_base,
    output logic [15:0]               req_len,
    output logic                      done
);
    localparam int TW     = $clog2(K + 2*DIM);
    localparam int LAST_T = K + 2*DIM - 2;

    logic [TW-1:0] t;
    logic [15:0]   op_len;
    logic          tile_end;

    assign op_len   = 16'(tc_pkg::operand_beats(DIM, K, elem_type) - 1);
    assign tile_end = in_valid && in_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= tc_pkg::IDLE;
            req_valid <= 1'b0;
            done      <= 1'b0;
            t         <= '0;
        end else begin
            done <= 1'b0;
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            case (phase)
                tc_pkg::IDLE: begin
                    if (start) begin
                        phase     <= tc_pkg::READ_C;
                        req_valid <= 1'b1;
                        req_sel   <= tc_pkg::MAT_C;
                        req_base  <= tc_pkg::C_BASE;
                        req_len   <= 16'(DIM*DIM - 1);    // One element per beat
                    end
                end
                tc_pkg::READ_C: begin
                    if (tile_end) begin
                        phase     <= tc_pkg::LOAD_A;
                        req_valid <= 1'b1;
                        req_sel   <= tc_pkg::MAT_A;
                        req_base  <= tc_pkg::A_BASE;
                        req_len   <= op_len;
                    end
                end
                tc_pkg::LOAD_A: begin
                    if (tile_end) begin
                        phase     <= tc_pkg::LOAD_B;
                        req_valid <= 1'b1;
                        req_sel   <= tc_pkg::MAT_B;
                        req_base  <= tc_pkg::B_BASE;
                        req_len   <= op_len;
                    end
                end
                tc_pkg::LOAD_B: begin
                    if (tile_end) begin
                        phase <= tc_pkg::COMPUTE;
                        t     <= '0;
                    end
                end
                tc_pkg::COMPUTE: begin
                    t <= t + 1'b1;
                    if (t == TW'(LAST_T)) begin    // Last skewed product lands here
                        phase <= tc_pkg::DRAIN;
                    end
                end
                tc_pkg::DRAIN: begin
                    if (drain_done) begin
                        phase <= tc_pkg::IDLE;
                        done  <= 1'b1;
                    end
                end
                default: phase <= tc_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tile_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tile_loader #(
    parameter int DIM = 4,
    parameter int K   = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  tc_pkg::phase_e            phase,
    input  tc_pkg::elem_type_e        elem_type,
    input  logic                      in_valid,
    input  logic [tc_pkg::WORD_W-1:0] in_data,
    operand_write_if.loader           wr
);
    localparam int CW = $clog2(DIM*DIM + DIM*K);
    localparam int RW = $clog2(DIM);
    localparam int KW = tc_pkg::pos_w(DIM, K);

    logic [CW-1:0] cnt;
    logic [CW-1:0] tile_last;
    logic          load_phase;

    assign load_phase   = phase inside {tc_pkg::READ_C, tc_pkg::LOAD_A, tc_pkg::LOAD_B};
    assign wr.we        = in_valid && load_phase;
    assign wr.lanes     = in_data;
    assign wr.word      = in_data;
    assign wr.elem_type = elem_type;

    always_comb begin
        case (phase)
            tc_pkg::READ_C: begin
                wr.mat    = tc_pkg::MAT_C;
                tile_last = CW'(DIM*DIM - 1);
            end
            tc_pkg::LOAD_A: begin
                wr.mat    = tc_pkg::MAT_A;
                tile_last = CW'(tc_pkg::operand_beats(DIM, K, elem_type) - 1);
            end
            default: begin
                wr.mat    = tc_pkg::MAT_B;
                tile_last = CW'(tc_pkg::operand_beats(DIM, K, elem_type) - 1);
            end
        endcase
    end

    // Beat count to position, each divisor a constant
    always_comb begin
        if (phase == tc_pkg::READ_C) begin
            wr.row    = RW'(int'(cnt) / DIM);
            wr.k_base = KW'(int'(cnt) % DIM);
        end else if (elem_type == tc_pkg::INT8) begin
            wr.row    = RW'(int'(cnt) / (K/4));
            wr.k_base = KW'((int'(cnt) % (K/4)) * 4);
        end else begin
            wr.row    = RW'(int'(cnt) / (K/8));
            wr.k_base = KW'((int'(cnt) % (K/8)) * 8);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !load_phase) begin
            cnt <= '0;
        end else if (wr.we) begin
            cnt <= (cnt == tile_last) ? '0 : cnt + 1'b1;    // Wraps for the next tile
        end
    end

endmodule

`default_nettype wire

// File: operand_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module operand_feeder #(
    parameter int DIM = 4,
    parameter int K   = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  tc_pkg::phase_e     phase,
    operand_write_if.sink      wr,
    output logic signed [7:0]  a_edge [DIM],
    output logic signed [7:0]  b_edge [DIM],
    output logic [DIM-1:0]     a_valid,
    output logic [DIM-1:0]     b_valid
);
    localparam int TW = $clog2(K + 2*DIM);

    logic signed [7:0] a_mem [DIM][K];    // A rows
    logic signed [7:0] b_mem [DIM][K];    // B columns
    logic [TW-1:0]     t;

    function automatic logic signed [7:0] lane_val(tc_pkg::lane_word_u w,
                                                   tc_pkg::elem_type_e e, int l);
        logic [2:0] sel;
        sel = 3'(l);
        if (e == tc_pkg::INT4) begin
            return {{4{w.i4[sel][3]}}, w.i4[sel]};
        end
        return w.i8[sel[1:0]];
    endfunction

    always_ff @(posedge clk) begin
        if (wr.we && wr.mat != tc_pkg::MAT_C) begin
            for (int l = 0; l < 8; l++) begin
                if (l < tc_pkg::lanes_per_word(wr.elem_type)) begin
                    if (wr.mat == tc_pkg::MAT_A) begin
                        a_mem[wr.row][int'(wr.k_base) + l] <= lane_val(wr.lanes, wr.elem_type, l);
                    end else begin
                        b_mem[wr.row][int'(wr.k_base) + l] <= lane_val(wr.lanes, wr.elem_type, l);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || phase != tc_pkg::COMPUTE) begin
            t <= '0;
        end else begin
            t <= t + 1'b1;
        end
    end

    // Row i and column i start i cycles late
    always_ff @(posedge clk) begin
        for (int i = 0; i < DIM; i++) begin
            if (phase == tc_pkg::COMPUTE && int'(t) >= i && int'(t) - i < K) begin
                a_edge[i]  <= a_mem[i][int'(t) - i];
                b_edge[i]  <= b_mem[i][int'(t) - i];
                a_valid[i] <= 1'b1;
                b_valid[i] <= 1'b1;
            end else begin
                a_edge[i]  <= '0;
                b_edge[i]  <= '0;
                a_valid[i] <= 1'b0;
                b_valid[i] <= 1'b0;
            end
            if (rst) begin
                a_valid[i] <= 1'b0;
                b_valid[i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: mac_array.sv
`timescale 1ns/1ps
`default_nettype none

module mac_array #(
    parameter int DIM = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  tc_pkg::phase_e    phase,
    input  logic signed [7:0] a_edge [DIM],
    input  logic signed [7:0] b_edge [DIM],
    input  logic [DIM-1:0]    a_valid,
    input  logic [DIM-1:0]    b_valid,
    operand_write_if.sink     wr,
    result_if.source          res
);
    logic                      en;
    logic signed [7:0]         a_in  [DIM][DIM];
    logic signed [7:0]         b_in  [DIM][DIM];
    logic                      av_in [DIM][DIM];
    logic                      bv_in [DIM][DIM];
    logic signed [7:0]         a_q   [DIM][DIM-1];    // Toward the right neighbour
    logic signed [7:0]         b_q   [DIM-1][DIM];    // Toward the cell below
    logic                      av_q  [DIM][DIM-1];
    logic                      bv_q  [DIM-1][DIM];
    logic [tc_pkg::WORD_W-1:0] acc   [DIM][DIM];

    assign en = phase == tc_pkg::COMPUTE;

    for (genvar i = 0; i < DIM; i++) begin : g_row
        for (genvar j = 0; j < DIM; j++) begin : g_col
            logic signed [15:0] prod;

            assign a_in[i][j]  = (j == 0) ? a_edge[i]  : a_q[i][(j == 0) ? 0 : j-1];
            assign av_in[i][j] = (j == 0) ? a_valid[i] : av_q[i][(j == 0) ? 0 : j-1];
            assign b_in[i][j]  = (i == 0) ? b_edge[j]  : b_q[(i == 0) ? 0 : i-1][j];
            assign bv_in[i][j] = (i == 0) ? b_valid[j] : bv_q[(i == 0) ? 0 : i-1][j];
            assign prod        = a_in[i][j] * b_in[i][j];

            if (j < DIM-1) begin : g_pass_a
                always_ff @(posedge clk) begin
                    if (en) begin
                        a_q[i][j] <= a_in[i][j];
                    end
                    av_q[i][j] <= (rst || !en) ? 1'b0 : av_in[i][j];
                end
            end

            if (i < DIM-1) begin : g_pass_b
                always_ff @(posedge clk) begin
                    if (en) begin
                        b_q[i][j] <= b_in[i][j];
                    end
                    bv_q[i][j] <= (rst || !en) ? 1'b0 : bv_in[i][j];
                end
            end

            always_ff @(posedge clk) begin
                if (wr.we && wr.mat == tc_pkg::MAT_C && int'(wr.row) == i
                        && int'(wr.k_base) == j) begin
                    acc[i][j] <= wr.word;    // Preload from C
                end else if (en && av_in[i][j] && bv_in[i][j]) begin
                    acc[i][j] <= acc[i][j] + {{16{prod[15]}}, prod};
                end
            end
        end
    end

    assign res.valid = phase == tc_pkg::DRAIN;
    assign res.last  = int'(res.index) == DIM*DIM - 1;

    // Row-major pick, zero past the end
    always_comb begin
        res.data = '0;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                if (int'(res.index) == i*DIM + j) begin
                    res.data = acc[i][j];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: result_drain.sv
`timescale 1ns/1ps
`default_nettype none

module result_drain #(
    parameter int DIM = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  tc_pkg::phase_e            phase,
    input  logic                      out_ready,
    result_if.drain                   res,
    output logic                      out_valid,
    output logic [tc_pkg::WORD_W-1:0] out_data,
    output logic                      out_last,
    output logic                      drain_done
);
    localparam int IW = $clog2(DIM*DIM + 1);

    logic [IW-1:0] nxt;
    logic          xfer;
    logic          load;

    assign res.ready  = out_ready;
    assign out_valid  = res.valid;
    assign xfer       = res.valid && res.ready;
    assign load       = phase != tc_pkg::DRAIN || xfer;    // Prefetch word 0 before DRAIN
    assign res.index  = (phase == tc_pkg::DRAIN) ? nxt : '0;
    assign drain_done = xfer && out_last;

    always_ff @(posedge clk) begin
        if (rst || phase != tc_pkg::DRAIN) begin
            nxt <= IW'(1);
        end else if (xfer) begin
            nxt <= nxt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= res.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_last <= 1'b0;
        end else if (load) begin
            out_last <= res.last;
        end
    end

endmodule

`default_nettype wire

// File: tensor_core.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_core #(
    parameter int DIM = 4,
    parameter int K   = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  tc_pkg::elem_type_e        elem_type,
    output logic                      req_valid,
    input  logic                      req_ready,
    output tc_pkg::mat_sel_e          req_sel,
    output logic [tc_pkg::WORD_W-1:0] req_base,
    output logic [15:0]               req_len,
    input  logic                      in_valid,
    input  logic [tc_pkg::WORD_W-1:0] in_data,
    input  logic                      in_last,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [tc_pkg::WORD_W-1:0] out_data,
    output logic                      out_last,
    output logic                      done
);
    tc_pkg::phase_e    phase;
    logic signed [7:0] a_edge [DIM];
    logic signed [7:0] b_edge [DIM];
    logic [DIM-1:0]    a_valid;
    logic [DIM-1:0]    b_valid;
    logic              drain_done;

    operand_write_if #(.DIM(DIM), .K(K)) op_wr ();
    result_if #(.DIM(DIM)) res_bus ();

    tc_sequencer #(.DIM(DIM), .K(K)) u_seq (
        .clk(clk), .rst(rst), .start(start), .elem_type(elem_type),
        .req_ready(req_ready), .in_valid(in_valid), .in_last(in_last),
        .drain_done(drain_done), .phase(phase), .req_valid(req_valid),
        .req_sel(req_sel), .req_base(req_base), .req_len(req_len), .done(done)
    );

    tile_loader #(.DIM(DIM), .K(K)) u_loader (
        .clk(clk), .rst(rst), .phase(phase), .elem_type(elem_type),
        .in_valid(in_valid), .in_data(in_data), .wr(op_wr.loader)
    );

    operand_feeder #(.DIM(DIM), .K(K)) u_feeder (
        .clk(clk), .rst(rst), .phase(phase), .wr(op_wr.sink),
        .a_edge(a_edge), .b_edge(b_edge), .a_valid(a_valid), .b_valid(b_valid)
    );

    mac_array #(.DIM(DIM)) u_array (
        .clk(clk), .rst(rst), .phase(phase), .a_edge(a_edge), .b_edge(b_edge),
        .a_valid(a_valid), .b_valid(b_valid), .wr(op_wr.sink), .res(res_bus.source)
    );

    result_drain #(.DIM(DIM)) u_drain (
        .clk(clk), .rst(rst), .phase(phase), .out_ready(out_ready),
        .res(res_bus.drain), .out_valid(out_valid), .out_data(out_data),
        .out_last(out_last), .drain_done(drain_done)
    );

endmodule

`default_nettype wire

// File: tensor_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_core_asserts (
    input logic        clk,
    input logic        rst,
    input logic        req_valid,
    input logic        req_ready,
    input logic [1:0]  req_sel,
    input logic [31:0] req_base,
    input logic [15:0] req_len,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] out_data,
    input logic        out_last,
    input logic        done
);
    // Request fields frozen until accepted
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_sel)
            && $stable(req_base) && $stable(req_len))
        else $error("request changed before req_ready");

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("output word changed under stall");

    // done follows the final output handshake and lasts one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(out_valid && out_ready && out_last) && !$past(done))
        else $error("done without a final output beat or longer than one cycle");

endmodule

bind tensor_core tensor_core_asserts u_asserts (.*);

`default_nettype wire

// File: tb_tensor_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tensor_core;
    localparam int DIM = 4;
    localparam int K   = 8;
    localparam int NC  = DIM * DIM;

    logic        clk;
    logic        rst;
    logic        start;
    logic        elem_type;
    logic        req_valid;
    logic        req_ready;
    logic [1:0]  req_sel;
    logic [31:0] req_base;
    logic [15:0] req_len;
    logic        in_valid;
    logic [31:0] in_data;
    logic        in_last;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_data;
    logic        out_last;
    logic        done;

    logic [31:0]     lfsr;
    logic [31:0]     c_w [NC];
    logic [31:0]     a_w [DIM*K];
    logic [31:0]     b_w [DIM*K];
    logic [31:0]     d_w [NC];
    logic [8*24-1:0] test_name;
    int              stall;
    int              op_beats;
    int              cyc;
    int              limit;
    int              n_req;
    int              n_done;

    tensor_core #(.DIM(DIM), .K(K)) dut (
        .clk(clk), .rst(rst), .start(start), .elem_type(tc_pkg::elem_type_e'(elem_type)),
        .req_valid(req_valid), .req_ready(req_ready), .req_sel(req_sel),
        .req_base(req_base), .req_len(req_len), .in_valid(in_valid), .in_data(in_data),
        .in_last(in_last), .out_valid(out_valid), .out_ready(out_ready),
        .out_data(out_data), .out_last(out_last), .done(done)
    );

    always #2 clk = ~clk;

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %0s %0s: expected %h, actual %h", test_name, what, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!rst && req_valid && req_ready) n_req <= n_req + 1;
        if (!rst && done) n_done <= n_done + 1;
        if (cyc > limit) begin
            $display("Timeout: the DUT did not finish the test in time");
            $display("Something failed");
            $fatal(1);
        end
    end

    // Answers one request, then sends its beats with random gaps
    task automatic serve_tile(input int sel, input logic [31:0] base, input int nbeats);
        logic b0;
        logic b1;
        int   gap;
        @(negedge clk);
        while (!req_valid) @(negedge clk);
        compare("req_sel", 32'(sel), 32'(req_sel));
        compare("req_base", base, req_base);
        compare("req_len", 32'(nbeats - 1), 32'(req_len));
        req_ready = 1'b1;
        @(negedge clk);
        req_ready = 1'b0;
        for (int i = 0; i < nbeats; i++) begin
            take_bit(b0);
            take_bit(b1);
            gap = int'({b1, b0});
            for (int g = 0; g < gap; g++) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_last  = (i == nbeats - 1);
            in_data  = (sel == 0) ? c_w[i] : (sel == 1) ? a_w[i] : b_w[i];
            start    = (sel == 0 && i == 0);    // Busy start that must be ignored
            @(negedge clk);
            start = 1'b0;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic collect_results();
        logic rdy;
        int   n;
        n = 0;
        while (n < NC) begin
            @(negedge clk);
            rdy = 1'b1;
            if (stall != 0 && out_valid) take_bit(rdy);
            out_ready = rdy;
            if (out_valid && rdy) begin
                compare($sformatf("d[%0d]", n), d_w[n], out_data);
                compare($sformatf("last[%0d]", n), 32'(n == NC - 1), 32'(out_last));
                n++;
            end
        end
        @(negedge clk);
        while (!done) @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic run_test(input int runs_before);
        op_beats = DIM * K / ((elem_type == 1'b1) ? 8 : 4);
        limit = cyc + 40 * (NC * 2 + op_beats * 2) + 200;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        fork
            begin
                serve_tile(0, 32'h0001_0000, NC);
                serve_tile(1, 32'h0010_0000, op_beats);
                serve_tile(2, 32'h0100_0000, op_beats);
            end
            collect_results();
        join
        @(negedge clk);
        compare("out_valid after done", 32'd0, 32'(out_valid));
        compare("done count", 32'(runs_before + 1), 32'(n_done));
        compare("request count", 32'(3 * (runs_before + 1)), 32'(n_req));
    endtask

    initial begin
        int    fd;
        int    et;
        int    runs;
        string line;
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        elem_type = 1'b0;
        req_ready = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_last = 1'b0;
        out_ready = 1'b0;
        lfsr = 32'h4117_2de2;
        cyc = 0;
        limit = 100;
        n_req = 0;
        n_done = 0;
        test_name = "reset";
        runs = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("tc_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tc_stim.txt");
            $display("Something failed");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%s %d %d", test_name, et, stall));
            elem_type = et[0];
            op_beats = DIM * K / ((et != 0) ? 8 : 4);
            for (int i = 0; i < NC; i++) void'($fscanf(fd, "%h", c_w[i]));
            for (int i = 0; i < op_beats; i++) void'($fscanf(fd, "%h", a_w[i]));
            for (int i = 0; i < op_beats; i++) void'($fscanf(fd, "%h", b_w[i]));
            for (int i = 0; i < NC; i++) void'($fscanf(fd, "%h", d_w[i]));
            run_test(runs);
            runs++;
        end
        $fclose(fd);
        if (runs == 0) begin
            $display("The stimulus file held no tests");
            $display("Something failed");
            $fatal(1);
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tc_stim.txt
# header: name elem_type(0 INT8, 1 INT4) stall_flag
# then hex lines: C row-major, A beats, B beats, expected D row-major
int8_basic 0 0
fffffff0 00000001 00000002 00000003 00000010 00000011 00000012 00000013 00000020 00000021 00000022 00000023 00000030 00000031 00000032 00000033
01010101 01010101 02020202 01010101 03030303 01010101 ffffffff 01010101
01010101 00000000 02020202 01010101 fdfdfdfd ffffffff 7f7f7f7f 02020202
fffffff4 0000000d fffffff2 00000207 00000018 00000025 fffffff6 00000413 0000002c 0000003d fffffffa 0000061f 0000002c 0000002d 0000003a fffffe3f

int4_basic 1 0
00000000 00000001 00000002 00000003 00000100 00000101 00000102 00000103 00000200 00000201 00000202 00000203 00000300 00000301 00000302 00000303
11111111 1111eeee 11117777 11118888
11113333 0000ffff dddd2222 77778888
00000010 fffffffd fffffffe ffffffff 000000ec 00000109 000000e6 0000015f 00000258 000001e5 0000022e 0000013f 000002a4 00000321 000002b6 0000041f

int8_stall 0 1
fffffff0 00000001 00000002 00000003 00000010 00000011 00000012 00000013 00000020 00000021 00000022 00000023 00000030 00000031 00000032 00000033
01010101 01010101 02020202 01010101 03030303 01010101 ffffffff 01010101
01010101 00000000 02020202 01010101 fdfdfdfd ffffffff 7f7f7f7f 02020202
fffffff4 0000000d fffffff2 00000207 00000018 00000025 fffffff6 00000413 0000002c 0000003d fffffffa 0000061f 0000002c 0000002d 0000003a fffffe3f

int4_stall 1 1
00000000 00000001 00000002 00000003 00000100 00000101 00000102 00000103 00000200 00000201 00000202 00000203 00000300 00000301 00000302 00000303
11111111 1111eeee 11117777 11118888
11113333 0000ffff dddd2222 77778888
00000010 fffffffd fffffffe ffffffff 000000ec 00000109 000000e6 0000015f 00000258 000001e5 0000022e 0000013f 000002a4 00000321 000002b6 0000041f

// File: list.f
tc_pkg.sv
tc_if.sv
tc_sequencer.sv
tile_loader.sv
operand_feeder.sv
mac_array.sv
result_drain.sv
tensor_core.sv
tensor_core_asserts.sv
tb_tensor_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_tensor_core \
    --Mdir obj_dir -f list.f
./obj_dir/Vtb_tensor_core
